// File: Bender.yml
package:
  name: nttw

sources:
  - frame_pkg.sv
  - mem_pkg.sv
  - frame_if.sv
  - buffer_ram.sv
  - in_copy.sv
  - out_stream.sv
  - frame_ctrl.sv
  - axil_status.sv
  - nttw_top.sv
  - target: test
    files:
      - tb_nttw.sv

// File: axil_status.sv
`timescale 1ns/1ns

module axil_status (
  input  logic                                 axi_clk,
  input  logic                                 axi_reset_n,
  input  logic                                 awvalid_i,
  input  logic                                 wvalid_i,
  input  logic [mem_pkg::axil_addr_width-1:0]  awaddr_i,
  input  logic [mem_pkg::axil_data_width-1:0]  wdata_i,
  input  logic                                 arvalid_i,
  input  logic [mem_pkg::axil_addr_width-1:0]  araddr_i,
  input  logic                                 rready_i,
  input  logic                                 done_i,
  output logic                                 awready_o,
  output logic                                 wready_o,
  output logic                                 arready_o,
  output logic                                 rvalid_o,
  output logic [mem_pkg::axil_data_width-1:0]  rdata_o,
  output logic                                 restart_o
);

  logic                                wr_accept;
  logic                                rd_busy;   // Address taken, response pending
  logic [mem_pkg::axil_addr_width-1:0] rd_addr;

  // Address and data must arrive together
  assign wr_accept = awvalid_i && wvalid_i;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign restart_o = wr_accept && awaddr_i == mem_pkg::status_addr && wdata_i[0];

  assign arready_o = 1'b1;

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      rd_busy <= 1'b0;
    end else if (!rd_busy) begin
      if (arvalid_i) rd_busy <= 1'b1;
    end else if (rready_i) begin
      rd_busy <= 1'b0;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!rd_busy && arvalid_i) begin
      rd_addr <= araddr_i;
    end
  end

  assign rvalid_o = rd_busy;
  assign rdata_o  = {{(mem_pkg::axil_data_width - 1){1'b0}},
                     done_i && rd_addr == mem_pkg::status_addr};

endmodule

// File: buffer_ram.sv
`timescale 1ns/1ns

module buffer_ram (
  input  logic                                axi_clk,
  input  logic                                wr_en_i,
  input  logic [mem_pkg::buf_addr_width-1:0]  wr_addr_i,
  input  logic [mem_pkg::buf_word_width-1:0]  wr_data_i,
  input  logic                                rd_en_i,
  input  logic [mem_pkg::buf_addr_width-1:0]  rd_addr_i,
  output logic [mem_pkg::buf_word_width-1:0]  rd_data_o
);

  logic [mem_pkg::buf_word_width-1:0] mem [mem_pkg::buf_depth];

  always_ff @(posedge axi_clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // One cycle read latency
  always_ff @(posedge axi_clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

// File: filelist.f
frame_pkg.sv
mem_pkg.sv
frame_if.sv
buffer_ram.sv
in_copy.sv
out_stream.sv
frame_ctrl.sv
axil_status.sv
nttw_top.sv
tb_nttw.sv

// File: frame_ctrl.sv
`timescale 1ns/1ns

module frame_ctrl (
  input  logic                 axi_clk,
  input  logic                 axi_reset_n,
  input  logic                 ss_tvalid_i,
  input  frame_pkg::cmd_word_u ss_tdata_i,
  input  logic                 restart_i,
  output logic                 ss_tready_o,
  output logic                 done_o,
  frame_if.ctrl                frame
);

  frame_pkg::phase_e phase;
  frame_pkg::phase_e phase_nxt;
  logic              mode_unpacked;
  logic              start_cmd;

  assign start_cmd = ss_tvalid_i && ss_tdata_i.cmd.opcode == frame_pkg::op_start;

  always_comb begin
    phase_nxt = phase;
    case (phase)
      frame_pkg::COMMAND: begin
        if (start_cmd) phase_nxt = frame_pkg::IN_COPY;   // Other beats are dropped
      end
      frame_pkg::IN_COPY: begin
        if (frame.load_done) phase_nxt = frame_pkg::OUT_COPY;
      end
      frame_pkg::OUT_COPY: begin
        if (frame.drain_done) phase_nxt = frame_pkg::DONE;
      end
      frame_pkg::DONE: begin
        if (restart_i) phase_nxt = frame_pkg::COMMAND;
      end
      default: phase_nxt = frame_pkg::COMMAND;
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      phase         <= frame_pkg::COMMAND;
      mode_unpacked <= 1'b0;
    end else begin
      phase <= phase_nxt;
      if (phase == frame_pkg::COMMAND && start_cmd) begin
        mode_unpacked <= ss_tdata_i.cmd.mode[1];   // Bit 0 has no effect
      end
    end
  end

  assign ss_tready_o = phase == frame_pkg::COMMAND || phase == frame_pkg::IN_COPY;
  assign done_o      = phase == frame_pkg::DONE;

  assign frame.mode_unpacked = mode_unpacked;
  assign frame.load_active   = phase == frame_pkg::IN_COPY;
  assign frame.drain_active  = phase == frame_pkg::OUT_COPY;

endmodule

// File: frame_if.sv
`timescale 1ns/1ns

interface frame_if;

  logic mode_unpacked;  // Latched from mode bit 1
  logic load_active;
  logic load_done;      // Last input beat accepted
  logic drain_active;
  logic drain_done;     // Last output beat accepted

  modport ctrl (
    output mode_unpacked,
    output load_active,
    output drain_active,
    input  load_done,
    input  drain_done
  );

  modport loader (
    input  mode_unpacked,
    input  load_active,
    output load_done
  );

  modport drainer (
    input  mode_unpacked,
    input  drain_active,
    output drain_done
  );

endinterface

// File: frame_pkg.sv
package frame_pkg;

  localparam int stream_width   = 32;
  localparam int unpacked_width = 16;   // Data bits carried by one unpacked beat

  localparam int full_beats     = 2048; // Two beats per buffer word
  localparam int unpacked_beats = 1024;
  localparam int beat_cnt_width = $clog2(full_beats);

  localparam logic [beat_cnt_width-1:0] full_last     = beat_cnt_width'(full_beats - 1);
  localparam logic [beat_cnt_width-1:0] unpacked_last = beat_cnt_width'(unpacked_beats - 1);

  localparam logic [1:0] op_start = 2'b01;

  // Output stage states
  localparam logic [1:0] os_wait = 2'd0;
  localparam logic [1:0] os_low  = 2'd1;
  localparam logic [1:0] os_high = 2'd2;
  localparam logic [1:0] os_unpk = 2'd3;

  typedef enum logic [1:0] {
    COMMAND,
    IN_COPY,
    OUT_COPY,
    DONE
  } phase_e;

  // A stream beat is a sample or, in COMMAND, a command
  typedef union packed {
    logic [stream_width-1:0] data;
    struct packed {
      logic [stream_width-5:0] unused;
      logic [1:0]              opcode;
      logic [1:0]              mode;   // Bit 1 selects unpacked mode
    } cmd;
  } cmd_word_u;

endpackage

// File: in_copy.sv
`timescale 1ns/1ns

module in_copy (
  input  logic                                axi_clk,
  input  logic                                axi_reset_n,
  input  logic                                ss_tvalid_i,
  input  frame_pkg::cmd_word_u                ss_tdata_i,
  frame_if.loader                             frame,
  output logic                                wr_en_o,
  output logic [mem_pkg::buf_addr_width-1:0]  wr_addr_o,
  output logic [mem_pkg::buf_word_width-1:0]  wr_data_o
);

  logic [frame_pkg::beat_cnt_width-1:0] beat_cnt;
  logic [frame_pkg::stream_width-1:0]   low_half;   // Even beat waiting for its partner
  logic                                 beat_acc;
  logic                                 last_beat;

  assign beat_acc  = frame.load_active && ss_tvalid_i;   // Ready is high all through IN_COPY
  assign last_beat = beat_cnt == (frame.mode_unpacked ? frame_pkg::unpacked_last
                                                      : frame_pkg::full_last);

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      beat_cnt <= '0;
    end else if (beat_acc) begin
      if (last_beat) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (beat_acc && !beat_cnt[0]) begin
      low_half <= ss_tdata_i.data;
    end
  end

  always_comb begin
    if (frame.mode_unpacked) begin
      wr_en_o   = beat_acc;
      wr_addr_o = beat_cnt[mem_pkg::buf_addr_width-1:0];
      wr_data_o = {{(mem_pkg::buf_word_width - frame_pkg::unpacked_width){1'b0}},
                   ss_tdata_i.data[frame_pkg::unpacked_width-1:0]};
    end else begin
      wr_en_o   = beat_acc && beat_cnt[0];   // Odd beat completes the word
      wr_addr_o = beat_cnt[frame_pkg::beat_cnt_width-1:1];
      wr_data_o = {ss_tdata_i.data, low_half};
    end
  end

  assign frame.load_done = beat_acc && last_beat;

endmodule

// File: mem_pkg.sv
package mem_pkg;

  localparam int buf_depth      = 1024;
  localparam int buf_addr_width = 10;
  localparam int buf_word_width = 64;   // Two full-mode beats

  localparam int axil_addr_width = 12;
  localparam int axil_data_width = 32;

  localparam logic [axil_addr_width-1:0] status_addr = '0;

endpackage

// File: nttw_top.sv
`timescale 1ns/1ns

module nttw_top (
  input  logic                                 axi_clk,
  input  logic                                 axi_reset_n,
  input  logic                                 awvalid_i,
  input  logic [mem_pkg::axil_addr_width-1:0]  awaddr_i,
  input  logic                                 wvalid_i,
  input  logic [mem_pkg::axil_data_width-1:0]  wdata_i,
  output logic                                 awready_o,
  output logic                                 wready_o,
  input  logic                                 arvalid_i,
  input  logic [mem_pkg::axil_addr_width-1:0]  araddr_i,
  output logic                                 arready_o,
  output logic                                 rvalid_o,
  output logic [mem_pkg::axil_data_width-1:0]  rdata_o,
  input  logic                                 rready_i,
  input  logic                                 ss_tvalid_i,
  input  logic [frame_pkg::stream_width-1:0]   ss_tdata_i,
  output logic                                 ss_tready_o,
  output logic                                 sm_tvalid_o,
  output logic [frame_pkg::stream_width-1:0]   sm_tdata_o,
  output logic                                 sm_tlast_o,
  input  logic                                 sm_tready_i
);

  logic                               restart;
  logic                               frame_done;
  logic                               buf_we;
  logic [mem_pkg::buf_addr_width-1:0] buf_wr_addr;
  logic [mem_pkg::buf_word_width-1:0] buf_wr_data;
  logic                               buf_rd_en;
  logic [mem_pkg::buf_addr_width-1:0] buf_rd_addr;
  logic [mem_pkg::buf_word_width-1:0] buf_rd_data;

  frame_if u_frame_if ();

  axil_status u_axil_status (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .awvalid_i   (awvalid_i),
    .wvalid_i    (wvalid_i),
    .awaddr_i    (awaddr_i),
    .wdata_i     (wdata_i),
    .arvalid_i   (arvalid_i),
    .araddr_i    (araddr_i),
    .rready_i    (rready_i),
    .done_i      (frame_done),
    .awready_o   (awready_o),
    .wready_o    (wready_o),
    .arready_o   (arready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .restart_o   (restart)
  );

  frame_ctrl u_frame_ctrl (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .ss_tvalid_i (ss_tvalid_i),
    .ss_tdata_i  (ss_tdata_i),
    .restart_i   (restart),
    .ss_tready_o (ss_tready_o),
    .done_o      (frame_done),
    .frame       (u_frame_if.ctrl)
  );

  in_copy u_in_copy (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .ss_tvalid_i (ss_tvalid_i),
    .ss_tdata_i  (ss_tdata_i),
    .frame       (u_frame_if.loader),
    .wr_en_o     (buf_we),
    .wr_addr_o   (buf_wr_addr),
    .wr_data_o   (buf_wr_data)
  );

  buffer_ram u_buffer_ram (
    .axi_clk   (axi_clk),
    .wr_en_i   (buf_we),
    .wr_addr_i (buf_wr_addr),
    .wr_data_i (buf_wr_data),
    .rd_en_i   (buf_rd_en),
    .rd_addr_i (buf_rd_addr),
    .rd_data_o (buf_rd_data)
  );

  out_stream u_out_stream (
    .axi_clk     (axi_clk),
    .axi_reset_n (axi_reset_n),
    .rd_data_i   (buf_rd_data),
    .sm_tready_i (sm_tready_i),
    .frame       (u_frame_if.drainer),
    .rd_en_o     (buf_rd_en),
    .rd_addr_o   (buf_rd_addr),
    .sm_tvalid_o (sm_tvalid_o),
    .sm_tdata_o  (sm_tdata_o),
    .sm_tlast_o  (sm_tlast_o)
  );

endmodule

// File: out_stream.sv
`timescale 1ns/1ns

module out_stream (
  input  logic                                axi_clk,
  input  logic                                axi_reset_n,
  input  logic [mem_pkg::buf_word_width-1:0]  rd_data_i,
  input  logic                                sm_tready_i,
  frame_if.drainer                            frame,
  output logic                                rd_en_o,
  output logic [mem_pkg::buf_addr_width-1:0]  rd_addr_o,
  output logic                                sm_tvalid_o,
  output logic [frame_pkg::stream_width-1:0]  sm_tdata_o,
  output logic                                sm_tlast_o
);

  logic [1:0]                           state;
  logic [1:0]                           state_nxt;
  logic [mem_pkg::buf_addr_width:0]     rd_cnt;     // Top bit set once every word is fetched
  logic                                 rd_pend;    // Read data arrives this cycle
  logic [mem_pkg::buf_word_width-1:0]   word_q;
  logic                                 unpk_valid;
  logic [frame_pkg::beat_cnt_width-1:0] beat_cnt;
  logic                                 beat_acc;

  assign beat_acc         = sm_tvalid_o && sm_tready_i;
  assign frame.drain_done = beat_acc && sm_tlast_o;
  assign rd_addr_o        = rd_cnt[mem_pkg::buf_addr_width-1:0];

  always_comb begin
    rd_en_o = 1'b0;
    if (frame.drain_active && !rd_pend && !rd_cnt[mem_pkg::buf_addr_width]) begin
      if (state == frame_pkg::os_wait) begin
        rd_en_o = !frame.mode_unpacked;
      end else if (state == frame_pkg::os_unpk) begin
        rd_en_o = !unpk_valid || beat_acc;   // Refill as the held beat leaves
      end
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      frame_pkg::os_wait: begin
        if (frame.drain_active) begin
          if (frame.mode_unpacked) begin
            state_nxt = frame_pkg::os_unpk;
          end else if (rd_pend) begin
            state_nxt = frame_pkg::os_low;
          end
        end
      end
      frame_pkg::os_low: begin
        if (sm_tready_i) state_nxt = frame_pkg::os_high;
      end
      frame_pkg::os_high: begin
        if (sm_tready_i) state_nxt = frame_pkg::os_wait;
      end
      frame_pkg::os_unpk: begin
        if (frame.drain_done) state_nxt = frame_pkg::os_wait;
      end
      default: state_nxt = frame_pkg::os_wait;
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_reset_n) begin
    if (!axi_reset_n) begin
      state      <= frame_pkg::os_wait;
      rd_pend    <= 1'b0;
      rd_cnt     <= '0;
      beat_cnt   <= '0;
      unpk_valid <= 1'b0;
    end else begin
      state   <= state_nxt;
      rd_pend <= rd_en_o;
      if (frame.drain_done) begin
        rd_cnt   <= '0;
        beat_cnt <= '0;
      end else begin
        if (rd_en_o) rd_cnt <= rd_cnt + 1'b1;
        if (beat_acc) beat_cnt <= beat_cnt + 1'b1;
      end
      if (state == frame_pkg::os_unpk && rd_pend) begin
        unpk_valid <= 1'b1;
      end else if (beat_acc) begin
        unpk_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (rd_pend) begin
      word_q <= rd_data_i;
    end
  end

  always_comb begin
    case (state)
      frame_pkg::os_low: begin
        sm_tvalid_o = 1'b1;
        sm_tdata_o  = word_q[frame_pkg::stream_width-1:0];   // Low half goes first
      end
      frame_pkg::os_high: begin
        sm_tvalid_o = 1'b1;
        sm_tdata_o  = word_q[mem_pkg::buf_word_width-1:frame_pkg::stream_width];
      end
      frame_pkg::os_unpk: begin
        sm_tvalid_o = unpk_valid;
        sm_tdata_o  = {{(frame_pkg::stream_width - frame_pkg::unpacked_width){1'b0}},
                       word_q[frame_pkg::unpacked_width-1:0]};
      end
      default: begin
        sm_tvalid_o = 1'b0;
        sm_tdata_o  = '0;
      end
    endcase
  end

  assign sm_tlast_o = sm_tvalid_o &&
                      beat_cnt == (frame.mode_unpacked ? frame_pkg::unpacked_last
                                                       : frame_pkg::full_last);

endmodule

// File: tb_nttw.sv
`timescale 1ns/1ns

module tb_nttw;

  localparam int cycle_limit = 40000;   // Four back-pressured frames of about 10000 cycles

  logic        axi_clk;
  logic        axi_reset_n;
  logic        awvalid_i;
  logic [11:0] awaddr_i;
  logic        wvalid_i;
  logic [31:0] wdata_i;
  logic        awready_o;
  logic        wready_o;
  logic        arvalid_i;
  logic [11:0] araddr_i;
  logic        arready_o;
  logic        rvalid_o;
  logic [31:0] rdata_o;
  logic        rready_i;
  logic        ss_tvalid_i;
  logic [31:0] ss_tdata_i;
  logic        ss_tready_o;
  logic        sm_tvalid_o;
  logic [31:0] sm_tdata_o;
  logic        sm_tlast_o;
  logic        sm_tready_i;

  integer      seed;
  int          error_count;
  int          cycle_count;
  int          tests_ok;
  int          tests_bad;
  int          errors_before;
  logic [31:0] status;
  logic [31:0] beat;
  logic [31:0] expect_q[$];   // Output beats in order

  nttw_top u_nttw_top (.*);

  initial begin
    axi_clk = 1'b0;
    forever #50 axi_clk = ~axi_clk;
  end

  always @(posedge axi_clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name);
    if (error_count == errors_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, error_count - errors_before);
      tests_bad++;
    end
    errors_before = error_count;
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    @(negedge axi_clk);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    check_value("arready_o", arready_o, 1);
    @(negedge axi_clk);
    arvalid_i = 1'b0;
    rready_i  = 1'b1;
    while (!rvalid_o) @(negedge axi_clk);
    data = rdata_o;
    @(negedge axi_clk);
    rready_i = 1'b0;
    check_value("rvalid_o", rvalid_o, 0);
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    @(negedge axi_clk);
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    awaddr_i  = addr;
    wdata_i   = data;
    @(posedge axi_clk);
    check_value("awready_o", awready_o, 1);
    check_value("wready_o", wready_o, 1);
    @(negedge axi_clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
  endtask

  task automatic send_beat(input logic [31:0] data);
    @(negedge axi_clk);
    ss_tvalid_i = 1'b1;
    ss_tdata_i  = data;
    while (!ss_tready_o) @(negedge axi_clk);
  endtask

  // Command beat and frame beats, with the expected output beats queued
  task automatic send_frame(input logic unpacked);
    logic [31:0] cmd;
    logic [31:0] data;
    int          n_beats;
    n_beats  = unpacked ? 1024 : 2048;
    cmd      = $random(seed);
    cmd[3:2] = 2'b01;
    cmd[1]   = unpacked;
    send_beat(cmd);
    for (int i = 0; i < n_beats; i++) begin
      data = $random(seed);
      send_beat(data);
      if (unpacked) expect_q.push_back({16'h0, data[15:0]});
      else expect_q.push_back(data);
    end
    @(negedge axi_clk);
    ss_tvalid_i = 1'b0;
  endtask

  task automatic receive_frame(input logic random_ready);
    logic [31:0] exp_data;
    logic        rdy;
    logic        seen_last;
    seen_last = 1'b0;
    while (!seen_last) begin
      @(negedge axi_clk);
      rdy         = random_ready ? (($random(seed) & 1) != 0) : 1'b1;
      sm_tready_i = rdy;
      if (sm_tvalid_o && rdy) begin
        if (expect_q.size() == 0) begin
          $display("output beat at %0t ns after the model ran out of beats", $time);
          error_count++;
          seen_last = 1'b1;
        end else begin
          exp_data = expect_q.pop_front();
          check_value("sm_tdata_o", sm_tdata_o, exp_data);
          check_value("sm_tlast_o", sm_tlast_o, expect_q.size() == 0);
          seen_last = sm_tlast_o || expect_q.size() == 0;
        end
      end
    end
    @(negedge axi_clk);
    sm_tready_i = 1'b1;
    check_value("beats left in model", expect_q.size(), 0);
    expect_q.delete();
  endtask

  initial begin
    seed          = 9;
    error_count   = 0;
    cycle_count   = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    errors_before = 0;
    axi_reset_n   = 1'b0;
    awvalid_i     = 1'b0;
    awaddr_i      = '0;
    wvalid_i      = 1'b0;
    wdata_i       = '0;
    arvalid_i     = 1'b0;
    araddr_i      = '0;
    rready_i      = 1'b0;
    ss_tvalid_i   = 1'b0;
    ss_tdata_i    = '0;
    sm_tready_i   = 1'b1;
    repeat (2) @(posedge axi_clk);
    @(negedge axi_clk);
    axi_reset_n = 1'b1;

    read_reg(12'h000, status);
    check_value("rdata_o", status, 0);
    check_value("sm_tvalid_o", sm_tvalid_o, 0);
    check_value("ss_tready_o", ss_tready_o, 1);
    report_test("1 reset state");

    send_frame(1'b0);
    receive_frame(1'b0);
    read_reg(12'h000, status);
    check_value("rdata_o", status, 1);
    report_test("2 full frame");
    write_reg(12'h000, 32'h1);

    send_frame(1'b1);
    receive_frame(1'b0);
    read_reg(12'h000, status);
    check_value("rdata_o", status, 1);
    report_test("3 unpacked frame");
    write_reg(12'h000, 32'h1);

    send_frame(1'b0);
    receive_frame(1'b1);
    read_reg(12'h000, status);
    check_value("rdata_o", status, 1);
    report_test("4 back-pressure");

    write_reg(12'h004, 32'h1);   // Wrong address
    read_reg(12'h000, status);
    check_value("rdata_o", status, 1);
    write_reg(12'h000, 32'h0);
    read_reg(12'h000, status);
    check_value("rdata_o", status, 1);
    write_reg(12'h000, 32'h1);
    read_reg(12'h000, status);
    check_value("rdata_o", status, 0);
    beat      = $random(seed);
    beat[3:2] = (beat[3:2] == 2'b01) ? 2'b11 : beat[3:2];
    beat[1]   = 1'b0;
    send_beat(beat);   // Would start a full frame if decoded as a command
    @(negedge axi_clk);
    ss_tvalid_i = 1'b0;
    send_frame(1'b1);
    receive_frame(1'b1);
    read_reg(12'h000, status);
    check_value("rdata_o", status, 1);
    report_test("5 restart");

    $display("tests: %0d ok, %0d with errors, %0d errors in total",
             tests_ok, tests_bad, error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
